// ==== rtl/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // data path and address widths
    localparam int xlen       = 32;
    localparam int csr_addr_w = 12;

    // SYSTEM major opcode, shared by all Zicsr instructions
    localparam logic [6:0] opcode_system = 7'b1110011;

    // csr operation, also the low two bits of funct3
    typedef enum logic [1:0] {
        csr_op_none = 2'b00,
        csr_op_rw   = 2'b01,
        csr_op_rs   = 2'b10,
        csr_op_rc   = 2'b11
    } csr_op_e;

    // machine-mode csr addresses
    localparam logic [csr_addr_w-1:0] addr_mstatus = 12'h300;
    localparam logic [csr_addr_w-1:0] addr_mtvec   = 12'h305;
    localparam logic [csr_addr_w-1:0] addr_mepc    = 12'h341;
    localparam logic [csr_addr_w-1:0] addr_mcause  = 12'h342;

    // mstatus field positions
    localparam int mie_bit  = 3;
    localparam int mpie_bit = 7;

    // MPP fixed at machine mode
    localparam logic [xlen-1:0] mstatus_reset = 32'h0000_1800;
    localparam logic [xlen-1:0] mtvec_reset   = 32'h0000_0000;
    localparam logic [xlen-1:0] mepc_reset    = 32'h0000_0000;
    localparam logic [xlen-1:0] mcause_reset  = 32'h0000_0000;

    // writable bits per register
    localparam logic [xlen-1:0] mstatus_wmask = 32'h0000_0088;
    localparam logic [xlen-1:0] mtvec_wmask   = 32'hffff_fffc;
    localparam logic [xlen-1:0] mepc_wmask    = 32'hffff_fffc;
    localparam logic [xlen-1:0] mcause_wmask  = 32'hffff_ffff;

endpackage

`default_nettype wire

// ==== rtl/csr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
    input  wire logic                       instr_valid_i,
    input  wire logic [31:0]                instr_i,
    input  wire logic [csr_pkg::xlen-1:0]   rs1_data_i,
    output logic                            req_o,
    output csr_pkg::csr_op_e                op_o,
    output logic [csr_pkg::csr_addr_w-1:0]  addr_o,
    output logic [csr_pkg::xlen-1:0]        wdata_o
);

    import csr_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [4:0]      rs1_field;
    logic            is_system;
    logic            is_csr;
    logic [xlen-1:0] imm_operand;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign rs1_field = instr_i[19:15];

    assign is_system = (opcode == opcode_system);
    // funct3 of 0 and 4 are not csr accesses
    assign is_csr    = is_system && (funct3[1:0] != 2'b00);

    assign req_o = instr_valid_i && is_csr;

    // csr address sits in the immediate field
    assign addr_o = instr_i[31:20];

    // zimm is the rs1 field, zero extended
    assign imm_operand = {{(xlen - 5){1'b0}}, rs1_field};

    always_comb begin
        if (!req_o) begin
            op_o = csr_op_none;
        end else begin
            case (funct3[1:0])
                2'b01:   op_o = csr_op_rw;
                2'b10:   op_o = csr_op_rs;
                2'b11:   op_o = csr_op_rc;
                default: op_o = csr_op_none;
            endcase
        end
    end

    // funct3[2] selects the immediate forms
    assign wdata_o = funct3[2] ? imm_operand : rs1_data_i;

endmodule

`default_nettype wire

// ==== rtl/csr_apb_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_apb_port (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       psel_i,
    input  wire logic                       penable_i,
    input  wire logic                       pwrite_i,
    input  wire logic [csr_pkg::csr_addr_w-1:0] paddr_i,
    input  wire logic [csr_pkg::xlen-1:0]   pwdata_i,
    input  wire logic                       gnt_i,
    input  wire logic [csr_pkg::xlen-1:0]   rdata_i,
    input  wire logic                       addr_hit_i,
    output logic [csr_pkg::xlen-1:0]        prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    output logic                            req_o,
    output csr_pkg::csr_op_e                op_o,
    output logic [csr_pkg::csr_addr_w-1:0]  addr_o,
    output logic [csr_pkg::xlen-1:0]        wdata_o
);

    import csr_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_done
    } state_e;

    state_e state;

    // no new request while the response is on the bus
    assign req_o   = psel_i && penable_i && (state != st_done);
    assign op_o    = pwrite_i ? csr_op_rw : csr_op_none;
    assign addr_o  = paddr_i;
    assign wdata_o = pwdata_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
        end else begin
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
            case (state)
                st_idle, st_wait: begin
                    if (req_o && gnt_i) begin
                        state     <= st_done;
                        pready_o  <= 1'b1;
                        pslverr_o <= ~addr_hit_i;
                    end else if (req_o) begin
                        // lost to the core or a trap, retry next cycle
                        state <= st_wait;
                    end
                end
                st_done: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // old value captured at the granted access
    always_ff @(posedge clk) begin
        if (req_o && gnt_i) begin
            prdata_o <= rdata_i;
        end
    end

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(penable_i) |-> psel_i
    );

    // master must hold the transfer while it stalls
    a_wait_holds_access: assert property (
        @(posedge clk) disable iff (!rst_n) (state == st_wait) |-> (psel_i && penable_i)
    );

endmodule

`default_nettype wire

// ==== rtl/csr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_arbiter (
    input  wire logic                       trap_i,
    input  wire logic                       dec_req_i,
    input  wire csr_pkg::csr_op_e           dec_op_i,
    input  wire logic [csr_pkg::csr_addr_w-1:0] dec_addr_i,
    input  wire logic [csr_pkg::xlen-1:0]   dec_wdata_i,
    input  wire logic                       host_req_i,
    input  wire csr_pkg::csr_op_e           host_op_i,
    input  wire logic [csr_pkg::csr_addr_w-1:0] host_addr_i,
    input  wire logic [csr_pkg::xlen-1:0]   host_wdata_i,
    output logic                            dec_gnt_o,
    output logic                            host_gnt_o,
    output logic                            req_valid_o,
    output csr_pkg::csr_op_e                req_op_o,
    output logic [csr_pkg::csr_addr_w-1:0]  req_addr_o,
    output logic [csr_pkg::xlen-1:0]        req_wdata_o
);

    import csr_pkg::*;

    // trap blocks both, the core beats the host
    assign dec_gnt_o   = dec_req_i && !trap_i;
    assign host_gnt_o  = host_req_i && !dec_req_i && !trap_i;
    assign req_valid_o = dec_gnt_o || host_gnt_o;

    // address follows the core whenever it asks so csr_rdata_o stays valid
    always_comb begin
        if (dec_req_i) begin
            req_addr_o  = dec_addr_i;
            req_wdata_o = dec_wdata_i;
            req_op_o    = dec_gnt_o ? dec_op_i : csr_op_none;
        end else begin
            req_addr_o  = host_addr_i;
            req_wdata_o = host_wdata_i;
            req_op_o    = host_gnt_o ? host_op_i : csr_op_none;
        end
    end

    always_comb begin
        a_one_grant: assert #0 (!(dec_gnt_o && host_gnt_o));
    end

endmodule

`default_nettype wire

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       req_valid_i,
    input  wire csr_pkg::csr_op_e           req_op_i,
    input  wire logic [csr_pkg::csr_addr_w-1:0] req_addr_i,
    input  wire logic [csr_pkg::xlen-1:0]   req_wdata_i,
    input  wire logic                       trap_i,
    input  wire logic [csr_pkg::xlen-1:0]   trap_pc_i,
    input  wire logic [csr_pkg::xlen-1:0]   trap_cause_i,
    output logic [csr_pkg::xlen-1:0]        rdata_o,
    output logic                            addr_hit_o,
    output logic [csr_pkg::xlen-1:0]        mtvec_o
);

    import csr_pkg::*;

    logic [xlen-1:0] mstatus_q;
    logic [xlen-1:0] mtvec_q;
    logic [xlen-1:0] mepc_q;
    logic [xlen-1:0] mcause_q;
    logic [xlen-1:0] new_val;
    logic            wr_en;

    // only masked bits take the new value
    function automatic logic [xlen-1:0] merge(
        input logic [xlen-1:0] old_val,
        input logic [xlen-1:0] wr_val,
        input logic [xlen-1:0] mask
    );
        merge = (old_val & ~mask) | (wr_val & mask);
    endfunction

    // read port, zero for unmapped addresses
    always_comb begin
        addr_hit_o = 1'b1;
        case (req_addr_i)
            addr_mstatus: rdata_o = mstatus_q;
            addr_mtvec:   rdata_o = mtvec_q;
            addr_mepc:    rdata_o = mepc_q;
            addr_mcause:  rdata_o = mcause_q;
            default: begin
                rdata_o    = '0;
                addr_hit_o = 1'b0;
            end
        endcase
    end

    // read-modify-write value from the old contents
    always_comb begin
        case (req_op_i)
            csr_op_rw: new_val = req_wdata_i;
            csr_op_rs: new_val = rdata_o | req_wdata_i;
            csr_op_rc: new_val = rdata_o & ~req_wdata_i;
            default:   new_val = rdata_o;
        endcase
    end

    assign wr_en = req_valid_i && (req_op_i != csr_op_none) && addr_hit_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= mstatus_reset;
            mtvec_q   <= mtvec_reset;
            mepc_q    <= mepc_reset;
            mcause_q  <= mcause_reset;
        end else if (trap_i) begin
            mepc_q              <= trap_pc_i & mepc_wmask;
            mcause_q            <= trap_cause_i & mcause_wmask;
            // interrupts off, previous enable saved
            mstatus_q[mpie_bit] <= mstatus_q[mie_bit];
            mstatus_q[mie_bit]  <= 1'b0;
        end else if (wr_en) begin
            case (req_addr_i)
                addr_mstatus: mstatus_q <= merge(mstatus_q, new_val, mstatus_wmask);
                addr_mtvec:   mtvec_q   <= merge(mtvec_q, new_val, mtvec_wmask);
                addr_mepc:    mepc_q    <= merge(mepc_q, new_val, mepc_wmask);
                addr_mcause:  mcause_q  <= merge(mcause_q, new_val, mcause_wmask);
                default:      mcause_q  <= mcause_q;
            endcase
        end
    end

    assign mtvec_o = mtvec_q;

    // arbiter must hold off all accesses in a trap cycle
    a_no_access_in_trap: assert property (
        @(posedge clk) disable iff (!rst_n) !(req_valid_i && trap_i)
    );

endmodule

`default_nettype wire

// ==== rtl/csr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       instr_valid_i,
    input  wire logic [31:0]                instr_i,
    input  wire logic [csr_pkg::xlen-1:0]   rs1_data_i,
    output logic [csr_pkg::xlen-1:0]        csr_rdata_o,
    input  wire logic                       psel_i,
    input  wire logic                       penable_i,
    input  wire logic                       pwrite_i,
    input  wire logic [csr_pkg::csr_addr_w-1:0] paddr_i,
    input  wire logic [csr_pkg::xlen-1:0]   pwdata_i,
    output logic [csr_pkg::xlen-1:0]        prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    input  wire logic                       trap_i,
    input  wire logic [csr_pkg::xlen-1:0]   trap_pc_i,
    input  wire logic [csr_pkg::xlen-1:0]   trap_cause_i,
    output logic [csr_pkg::xlen-1:0]        mtvec_o
);

    import csr_pkg::*;

    // instruction side request
    logic                  dec_req;
    csr_op_e               dec_op;
    logic [csr_addr_w-1:0] dec_addr;
    logic [xlen-1:0]       dec_wdata;

    // host side request
    logic                  host_req;
    csr_op_e               host_op;
    logic [csr_addr_w-1:0] host_addr;
    logic [xlen-1:0]       host_wdata;
    logic                  host_gnt;

    // arbitrated access into the register file
    logic                  req_valid;
    csr_op_e               req_op;
    logic [csr_addr_w-1:0] req_addr;
    logic [xlen-1:0]       req_wdata;
    logic [xlen-1:0]       rdata;
    logic                  addr_hit;

    csr_decode i_csr_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .req_o         (dec_req),
        .op_o          (dec_op),
        .addr_o        (dec_addr),
        .wdata_o       (dec_wdata)
    );

    csr_apb_port i_csr_apb_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .gnt_i      (host_gnt),
        .rdata_i    (rdata),
        .addr_hit_i (addr_hit),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .req_o      (host_req),
        .op_o       (host_op),
        .addr_o     (host_addr),
        .wdata_o    (host_wdata)
    );

    // the core never stalls, so its grant goes nowhere
    csr_arbiter i_csr_arbiter (
        .trap_i       (trap_i),
        .dec_req_i    (dec_req),
        .dec_op_i     (dec_op),
        .dec_addr_i   (dec_addr),
        .dec_wdata_i  (dec_wdata),
        .host_req_i   (host_req),
        .host_op_i    (host_op),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .dec_gnt_o    (),
        .host_gnt_o   (host_gnt),
        .req_valid_o  (req_valid),
        .req_op_o     (req_op),
        .req_addr_o   (req_addr),
        .req_wdata_o  (req_wdata)
    );

    csr_file i_csr_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid),
        .req_op_i     (req_op),
        .req_addr_i   (req_addr),
        .req_wdata_i  (req_wdata),
        .trap_i       (trap_i),
        .trap_pc_i    (trap_pc_i),
        .trap_cause_i (trap_cause_i),
        .rdata_o      (rdata),
        .addr_hit_o   (addr_hit),
        .mtvec_o      (mtvec_o)
    );

    // old value goes back to the core in the same cycle
    assign csr_rdata_o = rdata;

endmodule

`default_nettype wire

// ==== sim/tb_csr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csr_top;

    import csr_pkg::*;

    localparam int n_instr     = 200;
    localparam int n_apb       = 60;
    localparam int n_mixed     = 300;
    localparam int n_mixed_apb = 40;
    // apb transfers take about four cycles with margin for stalls and directed tests
    localparam int max_cycles  = 4 * (n_instr + 4 * n_apb + n_mixed + 260);

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid_i;
    logic [31:0]           instr_i;
    logic [xlen-1:0]       rs1_data_i;
    logic [xlen-1:0]       csr_rdata_o;
    logic                  psel_i;
    logic                  penable_i;
    logic                  pwrite_i;
    logic [csr_addr_w-1:0] paddr_i;
    logic [xlen-1:0]       pwdata_i;
    logic [xlen-1:0]       prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;
    logic                  trap_i;
    logic [xlen-1:0]       trap_pc_i;
    logic [xlen-1:0]       trap_cause_i;
    logic [xlen-1:0]       mtvec_o;

    // shadow copies of mstatus, mtvec, mepc and mcause
    logic [xlen-1:0]       shadow [0:3];
    logic                  resp_due;
    logic                  grant_now;
    logic [xlen-1:0]       exp_prdata;
    logic                  exp_slverr;
    logic [csr_addr_w-1:0] chk_addr;
    logic [2:0]            chk_funct3;
    logic [xlen-1:0]       chk_operand;
    int                    errors;
    int                    cycle_count;

    csr_top i_csr_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .csr_rdata_o   (csr_rdata_o),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .trap_i        (trap_i),
        .trap_pc_i     (trap_pc_i),
        .trap_cause_i  (trap_cause_i),
        .mtvec_o       (mtvec_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic int csr_index(input logic [csr_addr_w-1:0] addr);
        case (addr)
            addr_mstatus: return 0;
            addr_mtvec:   return 1;
            addr_mepc:    return 2;
            addr_mcause:  return 3;
            default:      return -1;
        endcase
    endfunction

    function automatic logic [xlen-1:0] wmask_of(input logic [csr_addr_w-1:0] addr);
        case (addr)
            addr_mstatus: return mstatus_wmask;
            addr_mtvec:   return mtvec_wmask;
            addr_mepc:    return mepc_wmask;
            addr_mcause:  return mcause_wmask;
            default:      return '0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] model_read(input logic [csr_addr_w-1:0] addr);
        int idx;
        idx = csr_index(addr);
        if (idx < 0) begin
            return '0;
        end
        return shadow[idx];
    endfunction

    // reference value stored after an access
    function automatic logic [xlen-1:0] model_csr(input csr_op_e op,
            input logic [csr_addr_w-1:0] addr, input logic [xlen-1:0] old_val,
            input logic [xlen-1:0] operand);
        logic [xlen-1:0] new_val;
        logic [xlen-1:0] mask;
        mask = wmask_of(addr);
        case (op)
            csr_op_rw: new_val = operand;
            csr_op_rs: new_val = old_val | operand;
            csr_op_rc: new_val = old_val & ~operand;
            default:   new_val = old_val;
        endcase
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    function automatic csr_op_e op_from_funct3(input logic [2:0] funct3);
        case (funct3[1:0])
            2'b01:   return csr_op_rw;
            2'b10:   return csr_op_rs;
            2'b11:   return csr_op_rc;
            default: return csr_op_none;
        endcase
    endfunction

    task automatic store_csr(input csr_op_e op, input logic [csr_addr_w-1:0] addr,
                             input logic [xlen-1:0] operand);
        int idx;
        idx = csr_index(addr);
        if (idx >= 0) begin
            shadow[idx] = model_csr(op, addr, shadow[idx], operand);
        end
    endtask

    task automatic apply_trap(input logic [xlen-1:0] pc, input logic [xlen-1:0] cause);
        shadow[2] = pc & ~32'h3;
        shadow[3] = cause;
        shadow[0][mpie_bit] = shadow[0][mie_bit];
        shadow[0][mie_bit]  = 1'b0;
    endtask

    // compares just after the falling edge once inputs and registers have settled
    always begin
        @(negedge clk);
        #5;
        if (rst_n) begin
            check_value("pready_o", pready_o, resp_due);
            if (resp_due) begin
                check_value("prdata_o", prdata_o, exp_prdata);
                check_value("pslverr_o", pslverr_o, exp_slverr);
            end
            check_value("mtvec_o", mtvec_o, shadow[1]);
            grant_now = 1'b0;
            if (instr_valid_i) begin
                chk_addr = instr_i[31:20];
                check_value("csr_rdata_o", csr_rdata_o, model_read(chk_addr));
            end
            if (trap_i) begin
                apply_trap(trap_pc_i, trap_cause_i);
            end else if (instr_valid_i) begin
                chk_funct3  = instr_i[14:12];
                chk_operand = chk_funct3[2] ? {27'b0, instr_i[19:15]} : rs1_data_i;
                store_csr(op_from_funct3(chk_funct3), chk_addr, chk_operand);
            end else if (psel_i && penable_i && !resp_due) begin
                // free access cycle serves the host
                exp_prdata = model_read(paddr_i);
                exp_slverr = (csr_index(paddr_i) < 0);
                if (pwrite_i) begin
                    store_csr(csr_op_rw, paddr_i, pwdata_i);
                end
                grant_now = 1'b1;
            end
            resp_due = grant_now;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > max_cycles) begin
            $display("timeout: no end of test after %0d cycles", max_cycles);
            $display("Testbench failed");
            $fatal(1, "run did not finish");
        end
    end

    function automatic logic [2:0] pick_funct3();
        int unsigned r;
        r = $urandom_range(0, 5);
        return (r < 3) ? 3'(r + 1) : 3'(r + 2);
    endfunction

    function automatic logic [csr_addr_w-1:0] pick_addr();
        logic [csr_addr_w-1:0] any_addr;
        any_addr = 12'($urandom);
        case ($urandom_range(0, 4))
            0:       return addr_mstatus;
            1:       return addr_mtvec;
            2:       return addr_mepc;
            3:       return addr_mcause;
            default: return any_addr;
        endcase
    endfunction

    task automatic apb_transfer(input logic write, input logic [csr_addr_w-1:0] addr,
            input logic [xlen-1:0] wdata, output logic [xlen-1:0] rdata,
            output logic slverr);
        @(negedge clk);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk);
        penable_i = 1'b1;
        @(negedge clk);
        while (!pready_o) begin
            @(negedge clk);
        end
        rdata  = prdata_o;
        slverr = pslverr_o;
        // response cycle closes on the next rising edge
        @(negedge clk);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic drive_instr(input logic [2:0] funct3, input logic [csr_addr_w-1:0] addr);
        logic [4:0] rs1_f;
        logic [4:0] rd_f;
        rs1_f = 5'($urandom);
        rd_f  = 5'($urandom);
        @(negedge clk);
        instr_valid_i = 1'b1;
        instr_i       = {addr, rs1_f, funct3, rd_f, opcode_system};
        rs1_data_i    = $urandom;
        trap_i        = 1'b0;
    endtask

    task automatic drive_trap(input logic [xlen-1:0] pc, input logic [xlen-1:0] cause);
        @(negedge clk);
        instr_valid_i = 1'b0;
        trap_i        = 1'b1;
        trap_pc_i     = pc;
        trap_cause_i  = cause;
    endtask

    // instruction in the trap cycle is dropped
    task automatic drive_trap_on_instr(input logic [xlen-1:0] pc,
                                       input logic [xlen-1:0] cause);
        drive_instr(pick_funct3(), pick_addr());
        trap_i       = 1'b1;
        trap_pc_i    = pc;
        trap_cause_i = cause;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        instr_valid_i = 1'b0;
        trap_i        = 1'b0;
    endtask

    task automatic random_apb();
        logic [xlen-1:0] rd;
        logic            err;
        apb_transfer(1'($urandom_range(0, 1)), pick_addr(), $urandom, rd, err);
    endtask

    initial begin
        logic [xlen-1:0] rd;
        logic            err;
        void'($urandom(32'haa4de7dd));
        errors = 0;
        cycle_count = 0;
        resp_due = 1'b0;
        rst_n = 1'b0;
        instr_valid_i = 1'b0;
        instr_i = '0;
        rs1_data_i = '0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        trap_i = 1'b0;
        trap_pc_i = '0;
        trap_cause_i = '0;
        shadow[0] = mstatus_reset;
        shadow[1] = mtvec_reset;
        shadow[2] = mepc_reset;
        shadow[3] = mcause_reset;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // reset values over apb
        check_value("mtvec_o", mtvec_o, 32'h0);
        apb_transfer(1'b0, addr_mstatus, '0, rd, err);
        check_value("prdata_o", rd, 32'h0000_1800);
        apb_transfer(1'b0, addr_mtvec, '0, rd, err);
        check_value("prdata_o", rd, 32'h0);
        apb_transfer(1'b0, addr_mepc, '0, rd, err);
        check_value("prdata_o", rd, 32'h0);
        apb_transfer(1'b0, addr_mcause, '0, rd, err);
        check_value("prdata_o", rd, 32'h0);

        // back to back instructions and a read of every csr
        repeat (n_instr) begin
            drive_instr(pick_funct3(), pick_addr());
        end
        drive_idle();
        apb_transfer(1'b0, addr_mstatus, '0, rd, err);
        apb_transfer(1'b0, addr_mtvec, '0, rd, err);
        apb_transfer(1'b0, addr_mepc, '0, rd, err);
        apb_transfer(1'b0, addr_mcause, '0, rd, err);

        repeat (n_apb) begin
            random_apb();
        end

        // trap with MIE set
        apb_transfer(1'b1, addr_mstatus, 32'h0000_0008, rd, err);
        drive_trap(32'h8000_1237, 32'h0000_000b);
        drive_idle();
        apb_transfer(1'b0, addr_mstatus, '0, rd, err);
        check_value("prdata_o", rd, 32'h0000_1880);
        apb_transfer(1'b0, addr_mepc, '0, rd, err);
        check_value("prdata_o", rd, 32'h8000_1234);
        apb_transfer(1'b0, addr_mcause, '0, rd, err);
        check_value("prdata_o", rd, 32'h0000_000b);

        // host traffic against a busy core
        fork
            begin
                repeat (n_mixed) begin
                    case ($urandom_range(0, 9))
                        0, 1, 2, 3, 4: drive_instr(pick_funct3(), pick_addr());
                        5:             drive_trap($urandom, $urandom);
                        6:             drive_trap_on_instr($urandom, $urandom);
                        default:       drive_idle();
                    endcase
                end
                drive_idle();
            end
            begin
                repeat (n_mixed_apb) begin
                    random_apb();
                end
            end
        join
        repeat (3) @(negedge clk);

        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/csr_pkg.sv
rtl/csr_decode.sv
rtl/csr_apb_port.sv
rtl/csr_arbiter.sv
rtl/csr_file.sv
rtl/csr_top.sv
sim/tb_csr_top.sv

// ==== Bender.yml ====
package:
  name: csr_subsystem

sources:
  - files:
      - rtl/csr_pkg.sv
      - rtl/csr_decode.sv
      - rtl/csr_apb_port.sv
      - rtl/csr_arbiter.sv
      - rtl/csr_file.sv
      - rtl/csr_top.sv
  - target: simulation
    files:
      - sim/tb_csr_top.sv
